//--- noc_flit_pkg.sv
// NoC flit format shared by the DMA target tile
// A flit is a 2-bit flit type on top of a 32-bit content word
// The content is read as a packet header or as one data word
// Encodings must match the rest of the network

package noc_flit_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Flit layout

  localparam int FLIT_WIDTH      = 34;
  localparam int CONTENT_WIDTH   = 32;
  localparam int TILE_WIDTH      = 5;
  localparam int PACKET_ID_WIDTH = 4;

  // Top two bits of a flit
  typedef enum logic [1:0] {
    FLIT_TYPE_PAYLOAD = 2'd0,
    FLIT_TYPE_HEADER  = 2'd1,
    FLIT_TYPE_LAST    = 2'd2,
    FLIT_TYPE_SINGLE  = 2'd3
  } flit_type_t;

  ////////////////////////////////////////////////////////////////////////////
  // Packet classes and types

  localparam logic [2:0] PACKET_CLASS_DMA = 3'd2;

  typedef enum logic [3:0] {
    PACKET_TYPE_L2R_REQ  = 4'd0,
    PACKET_TYPE_R2L_REQ  = 4'd1,
    PACKET_TYPE_L2R_RESP = 4'd2,
    PACKET_TYPE_R2L_RESP = 4'd3
  } packet_type_t;

  // Content word, header view or data view
  // Header fields from the top bit down
  typedef union packed {
    struct packed {
      logic [TILE_WIDTH-1:0]      dest;
      logic [2:0]                 pclass;
      logic [PACKET_ID_WIDTH-1:0] packet_id;
      logic [TILE_WIDTH-1:0]      source;
      packet_type_t               ptype;
      logic                       req_last;
      logic [9:0]                 reserved;
    } hdr;
    logic [CONTENT_WIDTH-1:0] data;
  } flit_content_u;

endpackage

//--- ahb_lite_pkg.sv
// AHB-Lite encodings and bus widths for the DMA master port
// Word transfers only, one address step of WORD_BYTES per beat
// Only incrementing bursts are issued

package ahb_lite_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus widths

  localparam int AHB_ADDR_WIDTH = 32;
  localparam int AHB_DATA_WIDTH = 32;

  // Byte step between consecutive beats
  localparam int WORD_BYTES = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Transfer types

  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  // Burst type of every write burst
  // Undefined length incrementing
  localparam logic [2:0] HBURST_INCR = 3'b001;

endpackage

//--- dma_packet_buffer.sv
// Flit FIFO between the NoC input and the write controller
// BUFFER_DEPTH must be a power of two, at least 2
// Output flit and valid are registered, no path from input to output
// Holds BUFFER_DEPTH flits plus one in the output register

module dma_packet_buffer
  import noc_flit_pkg::*;
#(
  parameter int BUFFER_DEPTH = 16
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [FLIT_WIDTH-1:0] in_flit,
  input  logic                  in_valid,
  output logic                  in_ready,
  output logic [FLIT_WIDTH-1:0] out_flit,
  output logic                  out_valid,
  input  logic                  out_ready
);

  localparam int PTR_WIDTH = $clog2(BUFFER_DEPTH);
  localparam logic [PTR_WIDTH:0] FULL_COUNT = (PTR_WIDTH + 1)'(BUFFER_DEPTH);

  // Storage behind the output register
  logic [FLIT_WIDTH-1:0] mem [BUFFER_DEPTH];
  logic [PTR_WIDTH-1:0]  wr_ptr;
  logic [PTR_WIDTH-1:0]  rd_ptr;
  logic [PTR_WIDTH:0]    count;

  logic push;
  logic out_free;
  logic mem_empty;
  logic load_mem;
  logic bypass;
  logic write_mem;

  // Ready only depends on the stored count
  assign in_ready  = (count != FULL_COUNT);
  assign push      = in_valid & in_ready;
  assign mem_empty = (count == '0);

  // Output register empty or emptied this cycle
  assign out_free  = ~out_valid | out_ready;
  assign load_mem  = out_free & ~mem_empty;

  // Straight into the output register when nothing is queued
  assign bypass    = push & out_free & mem_empty;
  assign write_mem = push & ~bypass;

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and occupancy

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap on their own, depth is a power of two
      if (write_mem) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (load_mem) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({write_mem, load_mem})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (write_mem) begin
      mem[wr_ptr] <= in_flit;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (out_free) begin
      out_valid <= load_mem | bypass;
    end
  end

  // Oldest stored flit first, keeps packet order
  always_ff @(posedge clk) begin
    if (load_mem) begin
      out_flit <= mem[rd_ptr];
    end else if (bypass) begin
      out_flit <= in_flit;
    end
  end

endmodule

//--- dma_l2r_write_ctrl.sv
// L2R request decoder and AHB-Lite write burst FSM
// Address and data of a beat share one cycle, a beat ends on hsel & hready
// Only header-type flits start a request, other flits in idle are dropped
// Non-L2R request packets are consumed and discarded

module dma_l2r_write_ctrl
  import noc_flit_pkg::*;
  import ahb_lite_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic [FLIT_WIDTH-1:0]      buf_flit,
  input  logic                       buf_valid,
  output logic                       buf_ready,
  output logic                       resp_valid,
  input  logic                       resp_ready,
  output logic [TILE_WIDTH-1:0]      resp_dest,
  output logic [PACKET_ID_WIDTH-1:0] resp_id,
  output logic                       ahb_hsel,
  output logic [1:0]                 ahb_htrans,
  output logic                       ahb_hwrite,
  output logic [AHB_ADDR_WIDTH-1:0]  ahb_haddr,
  output logic [AHB_DATA_WIDTH-1:0]  ahb_hwdata,
  input  logic                       ahb_hready
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_GET_ADDR,
    S_DATA,
    S_RESPOND
  } state_t;

  state_t state;
  state_t next_state;

  // Flit decode
  flit_type_t    ftype;
  flit_content_u content;
  logic          last_flit;
  logic          start_req;

  // Request parameters from the header
  logic [TILE_WIDTH-1:0]      src_tile;
  logic [PACKET_ID_WIDTH-1:0] packet_id;
  logic                       req_last;

  // Word address and burst position
  logic [AHB_ADDR_WIDTH-1:0] address;
  logic                      first_beat;
  logic                      beat_done;

  assign ftype     = flit_type_t'(buf_flit[FLIT_WIDTH-1 -: 2]);
  assign content   = buf_flit[CONTENT_WIDTH-1:0];
  assign last_flit = (ftype == FLIT_TYPE_LAST) | (ftype == FLIT_TYPE_SINGLE);

  // A new L2R request begins on a header flit with the L2R type
  assign start_req = buf_valid & (ftype == FLIT_TYPE_HEADER)
                   & (content.hdr.ptype == PACKET_TYPE_L2R_REQ);

  ////////////////////////////////////////////////////////////////////////////
  // AHB write port

  // Drive a beat only while a data flit is waiting
  assign ahb_hsel   = (state == S_DATA) & buf_valid;
  assign ahb_hwrite = (state == S_DATA);
  assign ahb_htrans = ~ahb_hsel  ? HTRANS_IDLE :
                      first_beat ? HTRANS_NONSEQ : HTRANS_SEQ;
  assign ahb_haddr  = address;
  assign ahb_hwdata = content.data;
  assign beat_done  = ahb_hsel & ahb_hready;

  // Header and address flits pop at once, data flits with their beat
  always_comb begin
    case (state)
      S_IDLE:     buf_ready = 1'b1;
      S_GET_ADDR: buf_ready = 1'b1;
      S_DATA:     buf_ready = ahb_hready;
      default:    buf_ready = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response hand-over

  assign resp_valid = (state == S_RESPOND);
  assign resp_dest  = src_tile;
  assign resp_id    = packet_id;

  ////////////////////////////////////////////////////////////////////////////
  // FSM

  always_comb begin
    next_state = state;
    case (state)
      S_IDLE: begin
        if (start_req) begin
          next_state = S_GET_ADDR;
        end
      end
      S_GET_ADDR: begin
        // Address flit that also closes the packet carries no data
        if (buf_valid & last_flit) begin
          next_state = req_last ? S_RESPOND : S_IDLE;
        end else if (buf_valid) begin
          next_state = S_DATA;
        end
      end
      S_DATA: begin
        if (beat_done & last_flit) begin
          next_state = req_last ? S_RESPOND : S_IDLE;
        end
      end
      S_RESPOND: begin
        if (resp_ready) begin
          next_state = S_IDLE;
        end
      end
      default: next_state = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= S_IDLE;
      first_beat <= 1'b0;
    end else begin
      state <= next_state;
      // NONSEQ until the first beat of the burst completes
      if (state == S_GET_ADDR) begin
        first_beat <= 1'b1;
      end else if (beat_done) begin
        first_beat <= 1'b0;
      end
    end
  end

  // Header fields latched as the header is consumed
  always_ff @(posedge clk) begin
    if (state == S_IDLE && start_req) begin
      src_tile  <= content.hdr.source;
      packet_id <= content.hdr.packet_id;
      req_last  <= content.hdr.req_last;
    end
  end

  // Base address, then one word per completed beat
  always_ff @(posedge clk) begin
    if (state == S_GET_ADDR && buf_valid) begin
      address <= content.data;
    end else if (beat_done) begin
      address <= address + AHB_ADDR_WIDTH'(WORD_BYTES);
    end
  end

endmodule

//--- dma_l2r_response.sv
// One-entry output register for the L2R response flit
// Flit is single type, addressed to the requesting tile
// Held stable until the NoC takes it

module dma_l2r_response
  import noc_flit_pkg::*;
#(
  parameter logic [TILE_WIDTH-1:0] TILE_ID = '0
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       resp_valid,
  output logic                       resp_ready,
  input  logic [TILE_WIDTH-1:0]      resp_dest,
  input  logic [PACKET_ID_WIDTH-1:0] resp_id,
  output logic [FLIT_WIDTH-1:0]      noc_out_flit,
  output logic                       noc_out_valid,
  input  logic                       noc_out_ready
);

  flit_content_u resp_content;
  logic          load;

  // Free slot, or the waiting flit leaves this cycle
  assign resp_ready = ~noc_out_valid | noc_out_ready;
  assign load       = resp_valid & resp_ready;

  // Response header, unused fields stay zero
  always_comb begin
    resp_content               = '0;
    resp_content.hdr.dest      = resp_dest;
    resp_content.hdr.pclass    = PACKET_CLASS_DMA;
    resp_content.hdr.packet_id = resp_id;
    resp_content.hdr.source    = TILE_ID;
    resp_content.hdr.ptype     = PACKET_TYPE_L2R_RESP;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      noc_out_valid <= 1'b0;
    end else if (load) begin
      noc_out_valid <= 1'b1;
    end else if (noc_out_ready) begin
      noc_out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      noc_out_flit <= {FLIT_TYPE_SINGLE, resp_content};
    end
  end

endmodule

//--- dma_target_ahb.sv
// DMA target tile, L2R writes from the NoC to an AHB-Lite master port
// Write responses go back to the requesting tile as single flits
// BUFFER_DEPTH must be a power of two, at least 2

module dma_target_ahb
  import noc_flit_pkg::*;
  import ahb_lite_pkg::*;
#(
  parameter logic [TILE_WIDTH-1:0] TILE_ID      = '0,
  parameter int                    BUFFER_DEPTH = 16
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [FLIT_WIDTH-1:0]     noc_in_flit,
  input  logic                      noc_in_valid,
  output logic                      noc_in_ready,
  output logic [FLIT_WIDTH-1:0]     noc_out_flit,
  output logic                      noc_out_valid,
  input  logic                      noc_out_ready,
  output logic                      ahb_hsel,
  output logic [1:0]                ahb_htrans,
  output logic                      ahb_hwrite,
  output logic [AHB_ADDR_WIDTH-1:0] ahb_haddr,
  output logic [AHB_DATA_WIDTH-1:0] ahb_hwdata,
  input  logic                      ahb_hready
);

  // Buffer to controller
  logic [FLIT_WIDTH-1:0] buf_flit;
  logic                  buf_valid;
  logic                  buf_ready;

  // Controller to response block
  logic                       resp_valid;
  logic                       resp_ready;
  logic [TILE_WIDTH-1:0]      resp_dest;
  logic [PACKET_ID_WIDTH-1:0] resp_id;

  dma_packet_buffer #(
    .BUFFER_DEPTH (BUFFER_DEPTH)
  ) packet_buffer_i (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (noc_in_flit),
    .in_valid  (noc_in_valid),
    .in_ready  (noc_in_ready),
    .out_flit  (buf_flit),
    .out_valid (buf_valid),
    .out_ready (buf_ready)
  );

  dma_l2r_write_ctrl write_ctrl_i (
    .clk        (clk),
    .rst        (rst),
    .buf_flit   (buf_flit),
    .buf_valid  (buf_valid),
    .buf_ready  (buf_ready),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp_dest  (resp_dest),
    .resp_id    (resp_id),
    .ahb_hsel   (ahb_hsel),
    .ahb_htrans (ahb_htrans),
    .ahb_hwrite (ahb_hwrite),
    .ahb_haddr  (ahb_haddr),
    .ahb_hwdata (ahb_hwdata),
    .ahb_hready (ahb_hready)
  );

  dma_l2r_response #(
    .TILE_ID (TILE_ID)
  ) response_i (
    .clk           (clk),
    .rst           (rst),
    .resp_valid    (resp_valid),
    .resp_ready    (resp_ready),
    .resp_dest     (resp_dest),
    .resp_id       (resp_id),
    .noc_out_flit  (noc_out_flit),
    .noc_out_valid (noc_out_valid),
    .noc_out_ready (noc_out_ready)
  );

endmodule

//--- tb_ahb_memory.sv
// AHB-Lite memory slave for the DMA target testbench
// Address and data of a write are taken in the same cycle, as the DUT drives them
// hready drops at random, about one cycle in four
// Every completed write is logged in order for the end-of-test compare

module tb_ahb_memory
  import ahb_lite_pkg::*;
#(
  parameter int SEED = 1
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      hsel,
  input  logic [1:0]                htrans,
  input  logic                      hwrite,
  input  logic [AHB_ADDR_WIDTH-1:0] haddr,
  input  logic [AHB_DATA_WIDTH-1:0] hwdata,
  output logic                      hready
);

  // Sparse storage, only written words exist
  logic [AHB_DATA_WIDTH-1:0] mem [logic [AHB_ADDR_WIDTH-1:0]];

  // Write log in bus order
  logic [AHB_ADDR_WIDTH-1:0] log_addr [$];
  logic [AHB_DATA_WIDTH-1:0] log_data [$];

  int seed = SEED;

  ////////////////////////////////////////////////////////////////////////////
  // Wait states

  // Changes on the falling edge only, stable at the rising edge
  initial begin
    hready = 1'b1;
    forever begin
      @(negedge clk);
      hready = ($unsigned($random(seed)) % 4) != 0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write capture

  // Beat completes on hsel and hready, IDLE transfers are ignored
  always @(posedge clk) begin
    if (!rst && hsel && hready && hwrite && htrans != HTRANS_IDLE) begin
      mem[haddr] = hwdata;
      log_addr.push_back(haddr);
      log_data.push_back(hwdata);
    end
  end

endmodule

//--- tb_dma_target.sv
// Testbench for the DMA target tile
// Random L2R, R2L and unknown request packets from a fixed seed
// Model queues of expected writes and response flits, checked live and at the end
// AHB wait states and NoC output stalls are random

module tb_dma_target
  import noc_flit_pkg::*;
  import ahb_lite_pkg::*;
();

  localparam int                    CLK_PERIOD   = 100;
  localparam int                    RESET_CYCLES = 10;
  localparam logic [TILE_WIDTH-1:0] TILE_ID      = 5'd3;
  localparam int                    NUM_PACKETS  = 40;
  localparam int                    MAX_WORDS    = 8;
  // Header, address and data flits
  localparam int                    MAX_FLITS    = MAX_WORDS + 2;
  localparam int WATCHDOG_CYCLES = NUM_PACKETS * MAX_FLITS * 20 + RESET_CYCLES;

  logic                      clk;
  logic                      rst;
  logic [FLIT_WIDTH-1:0]     noc_in_flit;
  logic                      noc_in_valid;
  logic                      noc_in_ready;
  logic [FLIT_WIDTH-1:0]     noc_out_flit;
  logic                      noc_out_valid;
  logic                      noc_out_ready;
  logic                      ahb_hsel;
  logic [1:0]                ahb_htrans;
  logic                      ahb_hwrite;
  logic [AHB_ADDR_WIDTH-1:0] ahb_haddr;
  logic [AHB_DATA_WIDTH-1:0] ahb_hwdata;
  logic                      ahb_hready;

  int seed       = 78381;
  int ready_seed = 78381 + 7;
  int errors     = 0;
  int checks     = 0;
  int beat_count = 0;

  // Model, expected writes in bus order and responses in request order
  logic [AHB_ADDR_WIDTH-1:0] exp_addr [$];
  logic [AHB_DATA_WIDTH-1:0] exp_data [$];
  bit                        exp_first [$];
  logic [FLIT_WIDTH-1:0]     exp_resp [$];

  // Values held over from the previous rising edge
  logic                      ahb_stalled;
  logic                      out_stalled;
  logic [AHB_ADDR_WIDTH-1:0] held_addr;
  logic [AHB_DATA_WIDTH-1:0] held_data;
  logic [FLIT_WIDTH-1:0]     held_flit;

  dma_target_ahb #(
    .TILE_ID      (TILE_ID),
    .BUFFER_DEPTH (16)
  ) dma_target_ahb_i (
    .clk           (clk),
    .rst           (rst),
    .noc_in_flit   (noc_in_flit),
    .noc_in_valid  (noc_in_valid),
    .noc_in_ready  (noc_in_ready),
    .noc_out_flit  (noc_out_flit),
    .noc_out_valid (noc_out_valid),
    .noc_out_ready (noc_out_ready),
    .ahb_hsel      (ahb_hsel),
    .ahb_htrans    (ahb_htrans),
    .ahb_hwrite    (ahb_hwrite),
    .ahb_haddr     (ahb_haddr),
    .ahb_hwdata    (ahb_hwdata),
    .ahb_hready    (ahb_hready)
  );

  tb_ahb_memory #(
    .SEED (78381)
  ) ahb_memory_i (
    .clk    (clk),
    .rst    (rst),
    .hsel   (ahb_hsel),
    .htrans (ahb_htrans),
    .hwrite (ahb_hwrite),
    .haddr  (ahb_haddr),
    .hwdata (ahb_hwdata),
    .hready (ahb_hready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int err_mark);
    $display("Test %s finished with %0d error(s)", name, errors - err_mark);
  endtask

  // Single-type L2R response, all unused bits zero
  function automatic logic [FLIT_WIDTH-1:0] resp_flit(input logic [TILE_WIDTH-1:0] dest,
                                                      input logic [PACKET_ID_WIDTH-1:0] id);
    return {FLIT_TYPE_SINGLE, dest, PACKET_CLASS_DMA, id, TILE_ID,
            PACKET_TYPE_L2R_RESP, 11'd0};
  endfunction

  // Falling edge drive with a random gap, held until the buffer takes it
  task automatic send_flit(input logic [FLIT_WIDTH-1:0] flit);
    int gap;
    gap = ($unsigned($random(seed)) % 4 == 0) ? 1 + $unsigned($random(seed)) % 3 : 0;
    repeat (gap) begin
      @(negedge clk);
      noc_in_valid = 1'b0;
    end
    @(negedge clk);
    noc_in_flit  = flit;
    noc_in_valid = 1'b1;
    // Ready only follows the buffer count, stable until the next rising edge
    while (!noc_in_ready) @(negedge clk);
  endtask

  // Header, base address, then 1 to MAX_WORDS data words
  task automatic send_packet();
    int                         n_words;
    int                         pick;
    logic [3:0]                 ptype;
    logic [TILE_WIDTH-1:0]      src;
    logic [PACKET_ID_WIDTH-1:0] id;
    logic                       req_last;
    logic [31:0]                base;
    logic [31:0]                word;
    logic [1:0]                 ftype;
    n_words  = 1 + $unsigned($random(seed)) % MAX_WORDS;
    pick     = $unsigned($random(seed)) % 10;
    src      = 5'($random(seed));
    id       = 4'($random(seed));
    req_last = 1'($random(seed));
    base     = $random(seed) & 32'hFFFF_FFFC;
    if (pick < 6) begin
      ptype = PACKET_TYPE_L2R_REQ;
    end else if (pick < 8) begin
      ptype = PACKET_TYPE_R2L_REQ;
    end else begin
      ptype = 4'(4 + $unsigned($random(seed)) % 12);
    end
    if (ptype == PACKET_TYPE_L2R_REQ && req_last) begin
      exp_resp.push_back(resp_flit(src, id));
    end
    send_flit({FLIT_TYPE_HEADER, TILE_ID, PACKET_CLASS_DMA, id, src, ptype, req_last, 10'd0});
    send_flit({FLIT_TYPE_PAYLOAD, base});
    for (int i = 0; i < n_words; i++) begin
      word  = $random(seed);
      ftype = (i == n_words - 1) ? FLIT_TYPE_LAST : FLIT_TYPE_PAYLOAD;
      // Only L2R data reaches the bus
      if (ptype == PACKET_TYPE_L2R_REQ) begin
        exp_addr.push_back(base + 32'(WORD_BYTES * i));
        exp_data.push_back(word);
        exp_first.push_back(i == 0);
      end
      send_flit({ftype, word});
    end
  endtask

  task automatic compare_write_log();
    check("write log length", ahb_memory_i.log_addr.size(), exp_addr.size());
    for (int i = 0; i < exp_addr.size() && i < ahb_memory_i.log_addr.size(); i++) begin
      check($sformatf("write %0d address", i), ahb_memory_i.log_addr[i], exp_addr[i]);
      check($sformatf("write %0d data", i), ahb_memory_i.log_data[i], exp_data[i]);
    end
  endtask

  // Final memory image, a later write to the same word wins
  task automatic compare_memory();
    logic [AHB_DATA_WIDTH-1:0] image [logic [AHB_ADDR_WIDTH-1:0]];
    for (int i = 0; i < exp_addr.size(); i++) begin
      image[exp_addr[i]] = exp_data[i];
    end
    check("memory word count", ahb_memory_i.mem.num(), image.num());
    foreach (image[a]) begin
      if (!ahb_memory_i.mem.exists(a)) begin
        errors++;
        $display("Memory word %0h was never written", a);
      end else begin
        check($sformatf("memory word %0h", a), ahb_memory_i.mem[a], image[a]);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Live monitor, samples at the rising edge

  always @(posedge clk) begin
    if (rst) begin
      ahb_stalled <= 1'b0;
      out_stalled <= 1'b0;
    end else begin
      // Wait state must not move the beat
      if (ahb_stalled) begin
        check("hsel under wait state", ahb_hsel, 1);
        check("haddr under wait state", ahb_haddr, held_addr);
        check("hwdata under wait state", ahb_hwdata, held_data);
      end
      if (out_stalled) begin
        check("noc_out_valid under back-pressure", noc_out_valid, 1);
        check("noc_out_flit under back-pressure", noc_out_flit, held_flit);
      end
      if (ahb_hsel && ahb_hready) begin
        if (beat_count < exp_first.size()) begin
          check("htrans", ahb_htrans, exp_first[beat_count] ? HTRANS_NONSEQ : HTRANS_SEQ);
        end else begin
          errors++;
          $display("AHB beat at %0t with no expected write left", $time);
        end
        check("hwrite on a beat", ahb_hwrite, 1);
        beat_count++;
      end
      if (noc_out_valid && noc_out_ready) begin
        if (exp_resp.size() == 0) begin
          errors++;
          $display("Response flit %0h at %0t was not expected", noc_out_flit, $time);
        end else begin
          check("response flit", noc_out_flit, exp_resp.pop_front());
        end
      end
      ahb_stalled <= ahb_hsel && !ahb_hready;
      out_stalled <= noc_out_valid && !noc_out_ready;
      held_addr   <= ahb_haddr;
      held_data   <= ahb_hwdata;
      held_flit   <= noc_out_flit;
    end
  end

  // NoC output back-pressure
  initial begin
    noc_out_ready = 1'b0;
    forever begin
      @(negedge clk);
      noc_out_ready = ($unsigned($random(ready_seed)) % 3) != 0;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout after %0d cycles, the DUT stopped making progress", WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    int err_mark;
    rst          = 1'b1;
    noc_in_flit  = '0;
    noc_in_valid = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    err_mark = errors;
    check("noc_out_valid after reset", noc_out_valid, 0);
    check("ahb_hsel after reset", ahb_hsel, 0);
    check("ahb_hwrite after reset", ahb_hwrite, 0);
    check("ahb_htrans after reset", ahb_htrans, HTRANS_IDLE);
    check("noc_in_ready after reset", noc_in_ready, 1);
    report_test("reset outputs", err_mark);

    err_mark = errors;
    for (int p = 0; p < NUM_PACKETS; p++) begin
      send_packet();
    end
    @(negedge clk);
    noc_in_valid = 1'b0;
    // Drain, then idle a while to catch stray beats or flits
    while (beat_count < exp_addr.size() || exp_resp.size() != 0) @(posedge clk);
    repeat (50) @(posedge clk);
    report_test("random packets", err_mark);

    err_mark = errors;
    compare_write_log();
    compare_memory();
    report_test("write log", err_mark);

    err_mark = errors;
    check("responses still pending", exp_resp.size(), 0);
    check("completed beats", beat_count, exp_addr.size());
    report_test("responses", err_mark);

    $display("Totals: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- project.f
noc_flit_pkg.sv
ahb_lite_pkg.sv
dma_packet_buffer.sv
dma_l2r_write_ctrl.sv
dma_l2r_response.sv
dma_target_ahb.sv
tb_ahb_memory.sv
tb_dma_target.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the DMA target testbench with Verilator and run it
# Exit status is zero only when the testbench reports a clean run

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_dma_target \
  -f project.f -o tb_dma_target_sim || { echo "Build failed"; exit 1; }

sim_output="$(./obj_dir/tb_dma_target_sim)"
echo "$sim_output"

echo "$sim_output" | grep -qx "Everything OK" && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
